// File: logic/mem_settings.svh
// bus widths, SRAM depth and SRAM response latency
// shared by the arbiter, the SRAM slave and the top level

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address width
`define MEM_ADDR_W 32

// data bus width in bits
`define MEM_DATA_W 32

// one strobe bit per data byte
`define MEM_STRB_W (`MEM_DATA_W / 8)

// SRAM depth in words
`define MEM_WORDS 1024

// cycles from address accept to response valid
`define SRAM_LATENCY 3

`endif

// File: logic/mem_pkg.sv
// arbiter and SRAM state encodings
// AXI-lite response codes

`default_nettype none

package mem_pkg;

	// arbiter grant state
	typedef enum logic [1:0] {
		ARB_IDLE      = 2'd0,
		ARB_BUSY_DATA = 2'd1,	// data port owns the SRAM
		ARB_BUSY_INST = 2'd2	// fetch port owns the SRAM
	} arb_state_t;

	// AXI response codes, only the two used here
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_t;

	// SRAM slave sequencing
	typedef enum logic [1:0] {
		SRAM_IDLE = 2'd0,
		SRAM_WAIT = 2'd1,	// latency countdown
		SRAM_RESP = 2'd2	// response held until ready
	} sram_state_t;

endpackage

`default_nettype wire

// File: logic/axi_arbiter.sv
// two-master to one-slave AXI-lite arbiter
// priority is data write, data read, then instruction read

`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module axi_arbiter (
	input  logic                     clk,
	input  logic                     rst,

	// instruction fetch port
	input  logic [`MEM_ADDR_W-1:0]   inst_ar_addr_i,
	input  logic                     inst_ar_valid_i,
	output logic                     inst_ar_ready_o,
	output logic [`MEM_DATA_W-1:0]   inst_r_data_o,
	output mem_pkg::axi_resp_t       inst_r_resp_o,
	output logic                     inst_r_valid_o,
	input  logic                     inst_r_ready_i,

	// data port
	input  logic [`MEM_ADDR_W-1:0]   data_ar_addr_i,
	input  logic                     data_ar_valid_i,
	output logic                     data_ar_ready_o,
	output logic [`MEM_DATA_W-1:0]   data_r_data_o,
	output mem_pkg::axi_resp_t       data_r_resp_o,
	output logic                     data_r_valid_o,
	input  logic                     data_r_ready_i,
	input  logic [`MEM_ADDR_W-1:0]   data_aw_addr_i,
	input  logic                     data_aw_valid_i,
	output logic                     data_aw_ready_o,
	input  logic [`MEM_DATA_W-1:0]   data_w_data_i,
	input  logic [`MEM_STRB_W-1:0]   data_w_strb_i,
	input  logic                     data_w_valid_i,
	output logic                     data_w_ready_o,
	output mem_pkg::axi_resp_t       data_b_resp_o,
	output logic                     data_b_valid_o,
	input  logic                     data_b_ready_i,

	// SRAM side
	output logic [`MEM_ADDR_W-1:0]   sram_ar_addr_o,
	output logic                     sram_ar_valid_o,
	input  logic                     sram_ar_ready_i,
	input  logic [`MEM_DATA_W-1:0]   sram_r_data_i,
	input  mem_pkg::axi_resp_t       sram_r_resp_i,
	input  logic                     sram_r_valid_i,
	output logic                     sram_r_ready_o,
	output logic [`MEM_ADDR_W-1:0]   sram_aw_addr_o,
	output logic                     sram_aw_valid_o,
	input  logic                     sram_aw_ready_i,
	output logic [`MEM_DATA_W-1:0]   sram_w_data_o,
	output logic [`MEM_STRB_W-1:0]   sram_w_strb_o,
	output logic                     sram_w_valid_o,
	input  logic                     sram_w_ready_i,
	input  mem_pkg::axi_resp_t       sram_b_resp_i,
	input  logic                     sram_b_valid_i,
	output logic                     sram_b_ready_o
);
	import mem_pkg::*;

	arb_state_t               state;
	arb_state_t               state_nxt;
	logic                     idle;
	logic                     grant_wr;
	logic                     grant_dr;
	logic                     grant_ir;
	logic                     grant_any;
	logic                     fwd_pending;	// captured request not yet taken by the SRAM
	logic                     req_is_write;
	logic [`MEM_ADDR_W-1:0]   req_addr;
	logic [`MEM_DATA_W-1:0]   req_wdata;
	logic [`MEM_STRB_W-1:0]   req_strb;
	logic                     busy_data;
	logic                     busy_inst;
	logic                     fwd_done;
	logic                     resp_done;

	assign idle      = (state == ARB_IDLE);
	assign busy_data = (state == ARB_BUSY_DATA);
	assign busy_inst = (state == ARB_BUSY_INST);

	// write needs AW and W together
	assign grant_wr  = idle & data_aw_valid_i & data_w_valid_i;
	assign grant_dr  = idle & ~grant_wr & data_ar_valid_i;
	assign grant_ir  = idle & ~grant_wr & ~data_ar_valid_i & inst_ar_valid_i;
	assign grant_any = grant_wr | grant_dr | grant_ir;

	assign data_aw_ready_o = grant_wr;
	assign data_w_ready_o  = grant_wr;
	assign data_ar_ready_o = grant_dr;
	assign inst_ar_ready_o = grant_ir;

	// forward the captured request
	assign sram_ar_addr_o  = req_addr;
	assign sram_aw_addr_o  = req_addr;
	assign sram_w_data_o   = req_wdata;
	assign sram_w_strb_o   = req_strb;
	assign sram_ar_valid_o = fwd_pending & ~req_is_write;
	assign sram_aw_valid_o = fwd_pending & req_is_write;
	assign sram_w_valid_o  = fwd_pending & req_is_write;

	assign fwd_done = req_is_write ? (sram_aw_valid_o & sram_aw_ready_i & sram_w_ready_i)
		: (sram_ar_valid_o & sram_ar_ready_i);

	// response steering, only the granted master sees a valid
	assign inst_r_data_o  = sram_r_data_i;
	assign inst_r_resp_o  = sram_r_resp_i;
	assign inst_r_valid_o = busy_inst & sram_r_valid_i;
	assign data_r_data_o  = sram_r_data_i;
	assign data_r_resp_o  = sram_r_resp_i;
	assign data_r_valid_o = busy_data & ~req_is_write & sram_r_valid_i;
	assign data_b_resp_o  = sram_b_resp_i;
	assign data_b_valid_o = busy_data & req_is_write & sram_b_valid_i;

	always_comb begin
		sram_r_ready_o = 1'b0;
		if (busy_inst)
			sram_r_ready_o = inst_r_ready_i;
		else if (busy_data & ~req_is_write)
			sram_r_ready_o = data_r_ready_i;
	end

	assign sram_b_ready_o = busy_data & req_is_write & data_b_ready_i;

	assign resp_done = (sram_r_valid_i & sram_r_ready_o) | (sram_b_valid_i & sram_b_ready_o);

	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE: begin
				if (grant_wr | grant_dr)
					state_nxt = ARB_BUSY_DATA;
				else if (grant_ir)
					state_nxt = ARB_BUSY_INST;
			end
			ARB_BUSY_DATA, ARB_BUSY_INST: begin
				if (resp_done)
					state_nxt = ARB_IDLE;	// any resp code ends it
			end
			default: state_nxt = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= ARB_IDLE;
			fwd_pending  <= 1'b0;
			req_is_write <= 1'b0;
		end else begin
			state <= state_nxt;
			if (grant_any) begin
				fwd_pending  <= 1'b1;
				req_is_write <= grant_wr;
			end else if (fwd_done) begin
				fwd_pending <= 1'b0;
			end
		end
	end

	// request payload capture
	always_ff @(posedge clk) begin
		if (grant_wr) begin
			req_addr  <= data_aw_addr_i;
			req_wdata <= data_w_data_i;
			req_strb  <= data_w_strb_i;
		end else if (grant_dr) begin
			req_addr <= data_ar_addr_i;
		end else if (grant_ir) begin
			req_addr <= inst_ar_addr_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/sram_axi_slave.sv
// AXI-lite SRAM slave with byte strobes
// fixed response latency, SLVERR beyond the memory size

`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module sram_axi_slave (
	input  logic                     clk,
	input  logic                     rst,

	input  logic [`MEM_ADDR_W-1:0]   ar_addr_i,
	input  logic                     ar_valid_i,
	output logic                     ar_ready_o,
	output logic [`MEM_DATA_W-1:0]   r_data_o,
	output mem_pkg::axi_resp_t       r_resp_o,
	output logic                     r_valid_o,
	input  logic                     r_ready_i,

	input  logic [`MEM_ADDR_W-1:0]   aw_addr_i,
	input  logic                     aw_valid_i,
	output logic                     aw_ready_o,
	input  logic [`MEM_DATA_W-1:0]   w_data_i,
	input  logic [`MEM_STRB_W-1:0]   w_strb_i,
	input  logic                     w_valid_i,
	output logic                     w_ready_o,
	output mem_pkg::axi_resp_t       b_resp_o,
	output logic                     b_valid_o,
	input  logic                     b_ready_i
);
	import mem_pkg::*;

	localparam int OFFS_W = $clog2(`MEM_STRB_W);
	localparam int IDX_W  = $clog2(`MEM_WORDS);
	localparam int CNT_W  = $clog2(`SRAM_LATENCY + 1);
	localparam logic [`MEM_ADDR_W-1:0] MEM_BYTES = `MEM_ADDR_W'(`MEM_WORDS * `MEM_STRB_W);
	localparam logic [CNT_W-1:0] LAT_LOAD = CNT_W'(`SRAM_LATENCY - 1);

	logic [`MEM_DATA_W-1:0]   mem [0:`MEM_WORDS-1];

	sram_state_t              state;
	sram_state_t              state_nxt;
	logic [CNT_W-1:0]         lat_cnt;
	logic                     idle;
	logic                     wr_go;
	logic                     rd_go;
	logic                     rd_in_range;
	logic                     wr_in_range;
	logic [IDX_W-1:0]         rd_idx;
	logic [IDX_W-1:0]         wr_idx;
	logic [`MEM_DATA_W-1:0]   rdata;
	axi_resp_t                resp_code;
	logic                     resp_is_write;
	logic                     resp_done;

	assign idle = (state == SRAM_IDLE);

	// AW and W only ever accepted together
	assign wr_go = idle & aw_valid_i & w_valid_i;
	assign rd_go = idle & ar_valid_i & ~(aw_valid_i & w_valid_i);

	assign aw_ready_o = wr_go;
	assign w_ready_o  = wr_go;
	assign ar_ready_o = rd_go;

	assign rd_in_range = (ar_addr_i < MEM_BYTES);
	assign wr_in_range = (aw_addr_i < MEM_BYTES);
	assign rd_idx      = ar_addr_i[OFFS_W +: IDX_W];	// word index
	assign wr_idx      = aw_addr_i[OFFS_W +: IDX_W];

	assign r_valid_o = (state == SRAM_RESP) & ~resp_is_write;
	assign b_valid_o = (state == SRAM_RESP) & resp_is_write;
	assign r_data_o  = rdata;
	assign r_resp_o  = resp_code;
	assign b_resp_o  = resp_code;

	assign resp_done = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i);

	always_comb begin
		state_nxt = state;
		case (state)
			SRAM_IDLE: begin
				if (wr_go | rd_go)
					state_nxt = (`SRAM_LATENCY == 1) ? SRAM_RESP : SRAM_WAIT;
			end
			SRAM_WAIT: begin
				if (lat_cnt == CNT_W'(1))
					state_nxt = SRAM_RESP;
			end
			SRAM_RESP: begin
				if (resp_done)
					state_nxt = SRAM_IDLE;
			end
			default: state_nxt = SRAM_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= SRAM_IDLE;
			lat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (wr_go | rd_go)
				lat_cnt <= LAT_LOAD;
			else if (state == SRAM_WAIT)
				lat_cnt <= lat_cnt - 1'b1;	// counts down to the response
		end
	end

	// memory array and response payload
	always_ff @(posedge clk) begin
		if (wr_go) begin
			resp_is_write <= 1'b1;
			resp_code     <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
			if (wr_in_range) begin
				for (int b = 0; b < `MEM_STRB_W; b++) begin
					if (w_strb_i[b])
						mem[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
				end
			end
		end else if (rd_go) begin
			resp_is_write <= 1'b0;
			resp_code     <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
			rdata         <= rd_in_range ? mem[rd_idx] : '0;	// zero on range error
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_subsys_top.sv
// memory subsystem top level
// arbiter in front of the SRAM slave

`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsys_top (
	input  logic                     clk,
	input  logic                     rst,

	input  logic [`MEM_ADDR_W-1:0]   inst_ar_addr_i,
	input  logic                     inst_ar_valid_i,
	output logic                     inst_ar_ready_o,
	output logic [`MEM_DATA_W-1:0]   inst_r_data_o,
	output mem_pkg::axi_resp_t       inst_r_resp_o,
	output logic                     inst_r_valid_o,
	input  logic                     inst_r_ready_i,

	input  logic [`MEM_ADDR_W-1:0]   data_ar_addr_i,
	input  logic                     data_ar_valid_i,
	output logic                     data_ar_ready_o,
	output logic [`MEM_DATA_W-1:0]   data_r_data_o,
	output mem_pkg::axi_resp_t       data_r_resp_o,
	output logic                     data_r_valid_o,
	input  logic                     data_r_ready_i,
	input  logic [`MEM_ADDR_W-1:0]   data_aw_addr_i,
	input  logic                     data_aw_valid_i,
	output logic                     data_aw_ready_o,
	input  logic [`MEM_DATA_W-1:0]   data_w_data_i,
	input  logic [`MEM_STRB_W-1:0]   data_w_strb_i,
	input  logic                     data_w_valid_i,
	output logic                     data_w_ready_o,
	output mem_pkg::axi_resp_t       data_b_resp_o,
	output logic                     data_b_valid_o,
	input  logic                     data_b_ready_i
);
	import mem_pkg::*;

	// arbiter to SRAM channels
	logic [`MEM_ADDR_W-1:0]   sram_ar_addr;
	logic                     sram_ar_valid;
	logic                     sram_ar_ready;
	logic [`MEM_DATA_W-1:0]   sram_r_data;
	axi_resp_t                sram_r_resp;
	logic                     sram_r_valid;
	logic                     sram_r_ready;
	logic [`MEM_ADDR_W-1:0]   sram_aw_addr;
	logic                     sram_aw_valid;
	logic                     sram_aw_ready;
	logic [`MEM_DATA_W-1:0]   sram_w_data;
	logic [`MEM_STRB_W-1:0]   sram_w_strb;
	logic                     sram_w_valid;
	logic                     sram_w_ready;
	axi_resp_t                sram_b_resp;
	logic                     sram_b_valid;
	logic                     sram_b_ready;

	axi_arbiter axi_arbiter_inst (
		.clk             (clk),
		.rst             (rst),
		.inst_ar_addr_i  (inst_ar_addr_i),
		.inst_ar_valid_i (inst_ar_valid_i),
		.inst_ar_ready_o (inst_ar_ready_o),
		.inst_r_data_o   (inst_r_data_o),
		.inst_r_resp_o   (inst_r_resp_o),
		.inst_r_valid_o  (inst_r_valid_o),
		.inst_r_ready_i  (inst_r_ready_i),
		.data_ar_addr_i  (data_ar_addr_i),
		.data_ar_valid_i (data_ar_valid_i),
		.data_ar_ready_o (data_ar_ready_o),
		.data_r_data_o   (data_r_data_o),
		.data_r_resp_o   (data_r_resp_o),
		.data_r_valid_o  (data_r_valid_o),
		.data_r_ready_i  (data_r_ready_i),
		.data_aw_addr_i  (data_aw_addr_i),
		.data_aw_valid_i (data_aw_valid_i),
		.data_aw_ready_o (data_aw_ready_o),
		.data_w_data_i   (data_w_data_i),
		.data_w_strb_i   (data_w_strb_i),
		.data_w_valid_i  (data_w_valid_i),
		.data_w_ready_o  (data_w_ready_o),
		.data_b_resp_o   (data_b_resp_o),
		.data_b_valid_o  (data_b_valid_o),
		.data_b_ready_i  (data_b_ready_i),
		.sram_ar_addr_o  (sram_ar_addr),
		.sram_ar_valid_o (sram_ar_valid),
		.sram_ar_ready_i (sram_ar_ready),
		.sram_r_data_i   (sram_r_data),
		.sram_r_resp_i   (sram_r_resp),
		.sram_r_valid_i  (sram_r_valid),
		.sram_r_ready_o  (sram_r_ready),
		.sram_aw_addr_o  (sram_aw_addr),
		.sram_aw_valid_o (sram_aw_valid),
		.sram_aw_ready_i (sram_aw_ready),
		.sram_w_data_o   (sram_w_data),
		.sram_w_strb_o   (sram_w_strb),
		.sram_w_valid_o  (sram_w_valid),
		.sram_w_ready_i  (sram_w_ready),
		.sram_b_resp_i   (sram_b_resp),
		.sram_b_valid_i  (sram_b_valid),
		.sram_b_ready_o  (sram_b_ready)
	);

	sram_axi_slave sram_axi_slave_inst (
		.clk        (clk),
		.rst        (rst),
		.ar_addr_i  (sram_ar_addr),
		.ar_valid_i (sram_ar_valid),
		.ar_ready_o (sram_ar_ready),
		.r_data_o   (sram_r_data),
		.r_resp_o   (sram_r_resp),
		.r_valid_o  (sram_r_valid),
		.r_ready_i  (sram_r_ready),
		.aw_addr_i  (sram_aw_addr),
		.aw_valid_i (sram_aw_valid),
		.aw_ready_o (sram_aw_ready),
		.w_data_i   (sram_w_data),
		.w_strb_i   (sram_w_strb),
		.w_valid_i  (sram_w_valid),
		.w_ready_o  (sram_w_ready),
		.b_resp_o   (sram_b_resp),
		.b_valid_o  (sram_b_valid),
		.b_ready_i  (sram_b_ready)
	);

endmodule

`default_nettype wire

// File: tb/mem_subsys_tb.sv
// testbench for the memory subsystem top level
// table of data and fetch transactions checked against a reference word array

`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsys_tb;
	import mem_pkg::*;

	localparam int AW          = `MEM_ADDR_W;
	localparam int DW          = `MEM_DATA_W;
	localparam int SW          = `MEM_STRB_W;
	localparam int OFFS_W      = $clog2(SW);
	localparam int IDX_W       = $clog2(`MEM_WORDS);
	localparam int MAX_DELAY   = 6;	// longest ready hold-off
	localparam int MAX_ENTRIES = 32;
	localparam logic [AW-1:0] MEM_BYTES = AW'(`MEM_WORDS * SW);
	localparam logic PORT_DATA = 1'b0;
	localparam logic PORT_INST = 1'b1;
	localparam logic OP_RD     = 1'b0;
	localparam logic OP_WR     = 1'b1;

	logic            clk;
	logic            rst;
	logic [AW-1:0]   inst_ar_addr_i;
	logic            inst_ar_valid_i;
	logic            inst_ar_ready_o;
	logic [DW-1:0]   inst_r_data_o;
	axi_resp_t       inst_r_resp_o;
	logic            inst_r_valid_o;
	logic            inst_r_ready_i;
	logic [AW-1:0]   data_ar_addr_i;
	logic            data_ar_valid_i;
	logic            data_ar_ready_o;
	logic [DW-1:0]   data_r_data_o;
	axi_resp_t       data_r_resp_o;
	logic            data_r_valid_o;
	logic            data_r_ready_i;
	logic [AW-1:0]   data_aw_addr_i;
	logic            data_aw_valid_i;
	logic            data_aw_ready_o;
	logic [DW-1:0]   data_w_data_i;
	logic [SW-1:0]   data_w_strb_i;
	logic            data_w_valid_i;
	logic            data_w_ready_o;
	axi_resp_t       data_b_resp_o;
	logic            data_b_valid_o;
	logic            data_b_ready_i;

	// stimulus table, one column per field
	logic            t_port  [MAX_ENTRIES];
	logic            t_write [MAX_ENTRIES];
	logic [AW-1:0]   t_addr  [MAX_ENTRIES];
	logic [DW-1:0]   t_wdata [MAX_ENTRIES];
	logic [SW-1:0]   t_strb  [MAX_ENTRIES];
	int              t_delay [MAX_ENTRIES];	// ready hold-off in cycles
	logic            t_simul [MAX_ENTRIES];	// next entry is a fetch raised alongside
	int              n_entries;

	logic [DW-1:0]   ref_mem [`MEM_WORDS];
	int              seed = 28;
	int              cycle = 0;
	int              timeout_limit = 0;
	int              cur_entry;
	int              entry_errors;
	int              pass_count = 0;
	int              fail_count = 0;

	// results of the data and fetch reads
	logic [DW-1:0]   pd_data;
	logic [DW-1:0]   pi_data;
	axi_resp_t       pd_resp;
	axi_resp_t       pi_resp;
	int              pd_grant;
	int              pd_done;
	int              pi_grant;
	int              pi_done;

	mem_subsys_top mem_subsys_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		wait (timeout_limit > 0);
		while (cycle < timeout_limit)
			@(posedge clk);
		$display("timeout after %0d cycles, a transaction never completed", cycle);
		$display("Regression failed");
		$finish;
	end

	function automatic logic addr_in_range(input logic [AW-1:0] addr);
		return addr < MEM_BYTES;
	endfunction

	function automatic logic [IDX_W-1:0] word_index(input logic [AW-1:0] addr);
		return addr[OFFS_W +: IDX_W];
	endfunction

	// strobed bytes from the new word, the rest kept
	function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
		input logic [DW-1:0] new_word, input logic [SW-1:0] strb);
		logic [DW-1:0] res;
		res = old_word;
		for (int b = 0; b < SW; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	function automatic int rand_delay();
		return 1 + int'($unsigned($random(seed)) % MAX_DELAY);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED test %0d: %s got %h expected %h", cur_entry, name, got, exp);
		entry_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("test %0d: %s", cur_entry, msg);
		entry_errors++;
	endtask

	task automatic add_entry(input logic port, input logic write, input logic [AW-1:0] addr,
		input logic [DW-1:0] wdata, input logic [SW-1:0] strb, input int delay,
		input logic simul);
		t_port[n_entries]  = port;
		t_write[n_entries] = write;
		t_addr[n_entries]  = addr;
		t_wdata[n_entries] = wdata;
		t_strb[n_entries]  = strb;
		t_delay[n_entries] = delay;
		t_simul[n_entries] = simul;
		n_entries++;
	endtask

	task automatic build_table();
		add_entry(PORT_DATA, OP_WR, 32'h0000_0010, 32'hdead_beef, 4'b1111, 0, 1'b0);
		add_entry(PORT_DATA, OP_RD, 32'h0000_0010, '0, '0, 0, 1'b0);
		// byte strobe merge on a fully written word
		add_entry(PORT_DATA, OP_WR, 32'h0000_0020, 32'h1122_3344, 4'b1111, 0, 1'b0);
		add_entry(PORT_DATA, OP_WR, 32'h0000_0020, 32'haabb_ccdd, 4'b0101, 0, 1'b0);
		add_entry(PORT_DATA, OP_RD, 32'h0000_0020, '0, '0, 0, 1'b0);
		// fetch reads what the data port wrote
		add_entry(PORT_DATA, OP_WR, 32'h0000_0104, 32'h0000_1013, 4'b1111, 0, 1'b0);
		add_entry(PORT_INST, OP_RD, 32'h0000_0104, '0, '0, 0, 1'b0);
		add_entry(PORT_DATA, OP_WR, 32'h0000_0ffc, 32'hcafe_f00d, 4'b1111, 1, 1'b0);
		add_entry(PORT_INST, OP_RD, 32'h0000_0ffc, '0, '0, 0, 1'b0);
		// 0x1010 would land on word 4 without the range check
		add_entry(PORT_DATA, OP_WR, 32'h0000_1010, 32'h5555_5555, 4'b1111, 0, 1'b0);
		add_entry(PORT_DATA, OP_RD, 32'h0000_2000, '0, '0, 0, 1'b0);
		add_entry(PORT_INST, OP_RD, 32'h0000_1000, '0, '0, 0, 1'b0);
		add_entry(PORT_DATA, OP_RD, 32'h0000_0010, '0, '0, 0, 1'b0);
		// data read and fetch raised in the same cycle
		add_entry(PORT_DATA, OP_RD, 32'h0000_0104, '0, '0, rand_delay(), 1'b1);
		add_entry(PORT_INST, OP_RD, 32'h0000_0020, '0, '0, 0, 1'b0);
		// back-pressure on every response channel
		add_entry(PORT_DATA, OP_RD, 32'h0000_0010, '0, '0, rand_delay(), 1'b0);
		add_entry(PORT_INST, OP_RD, 32'h0000_0ffc, '0, '0, rand_delay(), 1'b0);
		add_entry(PORT_DATA, OP_WR, 32'h0000_0020, 32'h7700_0000, 4'b1000, rand_delay(), 1'b0);
		add_entry(PORT_DATA, OP_RD, 32'h0000_0020, '0, '0, rand_delay(), 1'b0);
	endtask

	// no response may show up on the other channels
	task automatic check_quiet(input logic is_inst, input logic is_write);
		if (is_inst)
			assert (!data_r_valid_o && !data_b_valid_o) else
				report_problem("data-side response valid during a fetch");
		else if (is_write)
			assert (!inst_r_valid_o && !data_r_valid_o) else
				report_problem("read response valid during a write");
		else
			assert (!inst_r_valid_o && !data_b_valid_o) else
				report_problem("foreign response valid during a data read");
	endtask

	task automatic do_read(input logic is_inst, input logic [AW-1:0] addr, input int delay,
		output logic [DW-1:0] rd_data, output axi_resp_t rd_resp, output int grant_cyc,
		output int done_cyc);
		logic [DW-1:0] held_data;
		axi_resp_t     held_resp;
		@(negedge clk);
		if (is_inst) begin
			inst_ar_addr_i  = addr;
			inst_ar_valid_i = 1'b1;
		end else begin
			data_ar_addr_i  = addr;
			data_ar_valid_i = 1'b1;
		end
		#2;
		while (!(is_inst ? inst_ar_ready_o : data_ar_ready_o)) begin
			@(negedge clk);
			#2;
		end
		grant_cyc = cycle;
		@(negedge clk);
		inst_ar_valid_i = is_inst ? 1'b0 : inst_ar_valid_i;
		data_ar_valid_i = is_inst ? data_ar_valid_i : 1'b0;
		#2;
		while (!(is_inst ? inst_r_valid_o : data_r_valid_o)) begin
			check_quiet(is_inst, 1'b0);
			@(negedge clk);
			#2;
		end
		check_quiet(is_inst, 1'b0);	// the response cycle itself
		held_data = is_inst ? inst_r_data_o : data_r_data_o;
		held_resp = is_inst ? inst_r_resp_o : data_r_resp_o;
		repeat (delay) begin
			@(negedge clk);
			#2;
			assert (is_inst ? inst_r_valid_o : data_r_valid_o) else
				report_problem("R valid dropped before the handshake");
			assert ((is_inst ? inst_r_data_o : data_r_data_o) === held_data) else
				report_problem("R data changed while ready was low");
			assert ((is_inst ? inst_r_resp_o : data_r_resp_o) === held_resp) else
				report_problem("R resp changed while ready was low");
			check_quiet(is_inst, 1'b0);
		end
		@(negedge clk);
		if (is_inst)
			inst_r_ready_i = 1'b1;
		else
			data_r_ready_i = 1'b1;
		#2;
		assert (is_inst ? inst_r_valid_o : data_r_valid_o) else
			report_problem("R valid low when ready was raised");
		rd_data  = is_inst ? inst_r_data_o : data_r_data_o;
		rd_resp  = is_inst ? inst_r_resp_o : data_r_resp_o;
		done_cyc = cycle;
		@(negedge clk);
		inst_r_ready_i = 1'b0;
		data_r_ready_i = 1'b0;
	endtask

	task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
		input logic [SW-1:0] strb, input int delay, output axi_resp_t wr_resp);
		axi_resp_t held_resp;
		@(negedge clk);
		data_aw_addr_i  = addr;
		data_w_data_i   = wdata;
		data_w_strb_i   = strb;
		data_aw_valid_i = 1'b1;
		data_w_valid_i  = 1'b1;
		#2;
		while (!data_aw_ready_o) begin
			@(negedge clk);
			#2;
		end
		assert (data_w_ready_o) else
			report_problem("W ready not raised together with AW ready");
		@(negedge clk);
		data_aw_valid_i = 1'b0;
		data_w_valid_i  = 1'b0;
		#2;
		while (!data_b_valid_o) begin
			check_quiet(1'b0, 1'b1);
			@(negedge clk);
			#2;
		end
		check_quiet(1'b0, 1'b1);
		held_resp = data_b_resp_o;
		repeat (delay) begin
			@(negedge clk);
			#2;
			assert (data_b_valid_o && data_b_resp_o === held_resp) else
				report_problem("B response not held while ready was low");
			check_quiet(1'b0, 1'b1);
		end
		@(negedge clk);
		data_b_ready_i = 1'b1;
		#2;
		assert (data_b_valid_o) else
			report_problem("B valid low when ready was raised");
		wr_resp = data_b_resp_o;
		@(negedge clk);
		data_b_ready_i = 1'b0;
	endtask

	task automatic check_read(input int i, input logic [DW-1:0] got_data,
		input axi_resp_t got_resp);
		logic [DW-1:0] exp_data;
		axi_resp_t     exp_resp;
		exp_data = addr_in_range(t_addr[i]) ? ref_mem[word_index(t_addr[i])] : '0;
		exp_resp = addr_in_range(t_addr[i]) ? RESP_OKAY : RESP_SLVERR;
		assert (got_data === exp_data) else
			report_mismatch(t_port[i] ? "inst_r_data_o" : "data_r_data_o", got_data, exp_data);
		assert (got_resp === exp_resp) else
			report_mismatch(t_port[i] ? "inst_r_resp_o" : "data_r_resp_o",
				32'(got_resp), 32'(exp_resp));
	endtask

	task automatic run_write(input int i);
		axi_resp_t got_resp;
		axi_resp_t exp_resp;
		exp_resp = addr_in_range(t_addr[i]) ? RESP_OKAY : RESP_SLVERR;
		do_write(t_addr[i], t_wdata[i], t_strb[i], t_delay[i], got_resp);
		assert (got_resp === exp_resp) else
			report_mismatch("data_b_resp_o", 32'(got_resp), 32'(exp_resp));
		if (addr_in_range(t_addr[i]))
			ref_mem[word_index(t_addr[i])] =
				merge_bytes(ref_mem[word_index(t_addr[i])], t_wdata[i], t_strb[i]);
	endtask

	// data read first, fetch waits for the whole data response
	task automatic run_pair(input int i);
		fork
			do_read(1'b0, t_addr[i], t_delay[i], pd_data, pd_resp, pd_grant, pd_done);
			do_read(1'b1, t_addr[i+1], t_delay[i+1], pi_data, pi_resp, pi_grant, pi_done);
		join
		check_read(i, pd_data, pd_resp);
		check_read(i + 1, pi_data, pi_resp);
		assert (pd_grant < pi_grant) else
			report_problem("fetch address accepted before the data read");
		assert (pi_grant > pd_done) else
			report_problem("fetch granted before the data response completed");
	endtask

	initial begin
		int i;
		rst             = 1'b1;
		inst_ar_addr_i  = '0;
		inst_ar_valid_i = 1'b0;
		inst_r_ready_i  = 1'b0;
		data_ar_addr_i  = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i  = 1'b0;
		data_aw_addr_i  = '0;
		data_aw_valid_i = 1'b0;
		data_w_data_i   = '0;
		data_w_strb_i   = '0;
		data_w_valid_i  = 1'b0;
		data_b_ready_i  = 1'b0;
		n_entries       = 0;
		build_table();
		timeout_limit = n_entries * (`SRAM_LATENCY + MAX_DELAY + 8);
		repeat (4) @(negedge clk);
		rst = 1'b0;

		i = 0;
		while (i < n_entries) begin
			cur_entry    = i;
			entry_errors = 0;
			if (t_simul[i]) begin
				run_pair(i);
			end else if (t_write[i]) begin
				run_write(i);
			end else begin
				do_read(t_port[i], t_addr[i], t_delay[i], pd_data, pd_resp, pd_grant, pd_done);
				check_read(i, pd_data, pd_resp);
			end
			if (entry_errors == 0) begin
				pass_count++;
				$display("test %0d ok, addr %h", i, t_addr[i]);
			end else begin
				fail_count++;
				$display("test %0d had %0d errors, addr %h", i, entry_errors, t_addr[i]);
			end
			i = t_simul[i] ? i + 2 : i + 1;	// a pair uses two rows
		end

		$display("tests ok %0d, tests with errors %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/mem_pkg.sv
logic/axi_arbiter.sv
logic/sram_axi_slave.sv
logic/mem_subsys_top.sv
tb/mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory subsystem testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mem_subsys_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f \
	--top-module mem_subsys_tb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Regression passed" "$LOG_FILE"; then
	exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
